/* strip_defs.svh */
`ifndef STRIP_DEFS_SVH
`define STRIP_DEFS_SVH

// Width of one stream beat in bits.
`define STRIP_DATA_W 64

// Entries held by the realign FIFO.
// Two are needed to build one output beat, so keep at least that many,
// and more to absorb output back-pressure.
`define STRIP_BUF_STAGES 4

// Beats are MSB first.
// Byte 0 of a packet sits in the top byte of its first beat.
// On a last beat, padbytes counts unused bytes at the low end.
// Padbytes is zero on every other beat.
// Header-kind opcodes live in hdr_pkg.

`endif

/* stream_pkg.sv */
`include "strip_defs.svh"

package stream_pkg;

    // One beat on the stream.
    typedef logic [`STRIP_DATA_W-1:0] data_t;

    // Unused low bytes on a last beat, 0 up to one less than the bytes per beat.
    typedef logic [$clog2(`STRIP_DATA_W/8)-1:0] padbytes_t;

    // Header bytes removed from the front of a packet.
    // Same range as padbytes, since less than one beat is ever stripped.
    typedef logic [$clog2(`STRIP_DATA_W/8)-1:0] strip_t;

    // A packet must be longer than its strip count.
    // Nothing in the stream types enforces that.
    // The classify stage attaches the count to every beat it forwards.

endpackage

/* hdr_pkg.sv */
package hdr_pkg;

    // Header-kind opcode, byte 0 of every packet.
    // Values not listed strip only the opcode byte itself.
    typedef enum logic [7:0] {
        KIND_RAW  = 8'd0, // Nothing stripped.
        KIND_TAG  = 8'd1, // 2 bytes.
        KIND_TUN  = 8'd2, // 4 bytes.
        KIND_LONG = 8'd3  // 6 bytes.
    } hdr_kind_e;

    // Classify stage position within a packet.
    typedef enum logic {
        POS_FIRST = 1'b0,
        POS_BODY  = 1'b1
    } pkt_pos_e;

    // Realign stage FSM.
    typedef enum logic [1:0] {
        WAITING       = 2'd0, // At a packet start, strip count taken from the head entry.
        READING_DATA  = 2'd1,
        DRAIN_ELEMENT = 2'd2  // Pop a last beat already merged into the output.
    } realign_state_e;

endpackage

/* peek_fifo.sv */
`timescale 1ns/100ps

module peek_fifo #(
    parameter int data_w = 8,
    parameter int els = 4
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 wr_req,
    input  logic [data_w-1:0]    wr_data,
    output logic                 full,

    input  logic                 rd_req,
    output logic [data_w-1:0]    rd_data,
    output logic [data_w-1:0]    rd_data_next,

    output logic [$clog2(els):0] num_els
);
    localparam int ptr_w = $clog2(els);

    logic [data_w-1:0] mem [els];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [ptr_w-1:0]  rd_ptr_inc;
    logic              do_wr;
    logic              do_rd;

    // Wraps explicitly so els need not be a power of two.
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(els - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (num_els == (ptr_w + 1)'(els));
    assign do_wr = wr_req & ~full;
    assign do_rd = rd_req & (num_els != '0);

    assign rd_ptr_inc = ptr_inc(rd_ptr);
    assign rd_data = mem[rd_ptr];
    assign rd_data_next = mem[rd_ptr_inc]; // Only meaningful with two or more entries.

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            num_els <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr_inc;
            end
            case ({do_wr, do_rd})
                2'b10: num_els <= num_els + 1'b1;
                2'b01: num_els <= num_els - 1'b1;
                default: num_els <= num_els; // Both or neither.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* hdr_classify.sv */
`timescale 1ns/100ps

module hdr_classify (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in_val,
    input  stream_pkg::data_t     in_data,
    input  stream_pkg::padbytes_t in_padbytes,
    input  logic                  in_last,
    output logic                  in_rdy,

    output logic                  cls_val,
    output stream_pkg::data_t     cls_data,
    output stream_pkg::padbytes_t cls_padbytes,
    output logic                  cls_last,
    output stream_pkg::strip_t    cls_strip,
    input  logic                  cls_rdy
);
    import stream_pkg::*;
    import hdr_pkg::*;

    pkt_pos_e  pos;
    hdr_kind_e kind;
    strip_t    kind_strip;
    strip_t    pkt_strip;
    strip_t    beat_strip;
    logic      in_take;

    // Slot frees up when empty or when the realign stage takes its beat.
    assign in_rdy = ~cls_val | cls_rdy;
    assign in_take = in_val & in_rdy;

    assign kind = hdr_kind_e'(in_data[$bits(data_t)-1 -: 8]); // Opcode byte.

    always_comb begin
        case (kind)
            KIND_RAW:  kind_strip = strip_t'(0);
            KIND_TAG:  kind_strip = strip_t'(2);
            KIND_TUN:  kind_strip = strip_t'(4);
            KIND_LONG: kind_strip = strip_t'(6);
            default:   kind_strip = strip_t'(1); // Reserved, drop the opcode only.
        endcase
    end

    assign beat_strip = (pos == POS_FIRST) ? kind_strip : pkt_strip;

    always_ff @(posedge clk) begin
        if (rst) begin
            pos <= POS_FIRST;
            cls_val <= 1'b0;
        end else begin
            if (in_take) begin
                pos <= in_last ? POS_FIRST : POS_BODY;
                cls_val <= 1'b1;
            end else if (cls_rdy) begin
                cls_val <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_take) begin
            cls_data <= in_data;
            cls_padbytes <= in_padbytes;
            cls_last <= in_last;
            cls_strip <= beat_strip;
            pkt_strip <= beat_strip; // Held for the body beats.
        end
    end

endmodule

/* realign_runtime.sv */
`timescale 1ns/100ps

module realign_runtime #(
    parameter int data_w = 64,
    parameter int buf_stages = 4
) (
    input  logic                  clk,
    input  logic                  rst,

    input  stream_pkg::strip_t    realign_bytes,

    input  logic                  src_realign_data_val,
    input  logic [data_w-1:0]     src_realign_data,
    input  stream_pkg::padbytes_t src_realign_data_padbytes,
    input  logic                  src_realign_data_last,
    output logic                  realign_src_data_rdy,

    output logic                  realign_dst_data_val,
    output logic [data_w-1:0]     realign_dst_data,
    output stream_pkg::padbytes_t realign_dst_data_padbytes,
    output logic                  realign_dst_data_last,
    input  logic                  dst_realign_data_rdy
);
    import stream_pkg::*;
    import hdr_pkg::*;

    localparam int line_bytes = data_w / 8;
    localparam int bcnt_w = $clog2(line_bytes) + 1;
    localparam int shift_w = $clog2(data_w);

    typedef struct packed {
        logic [data_w-1:0] data;
        logic              last;
        padbytes_t         padbytes;
        strip_t            strip;
    } entry_t;

    realign_state_e              state;
    realign_state_e              state_next;

    entry_t                      fifo_wr_data;
    entry_t                      fifo_rd_data;
    entry_t                      fifo_rd_data_next;
    logic                        fifo_wr_req;
    logic                        fifo_rd_req;
    logic                        fifo_full;
    logic [$clog2(buf_stages):0] fifo_num_els;

    strip_t                      strip_reg;
    strip_t                      strip_cur;
    logic [bcnt_w-1:0]           use_bytes;
    logic [shift_w-1:0]          realign_shift;
    logic [data_w-1:0]           low_half;
    logic [2*data_w-1:0]         realign_data;
    logic                        merge_last;
    padbytes_t                   pad_src;

    assign fifo_wr_data.data = src_realign_data;
    assign fifo_wr_data.last = src_realign_data_last;
    assign fifo_wr_data.padbytes = src_realign_data_padbytes;
    assign fifo_wr_data.strip = realign_bytes;

    assign fifo_wr_req = src_realign_data_val & ~fifo_full;
    assign realign_src_data_rdy = ~fifo_full;

    // Strip count comes straight from the head entry at a packet start.
    assign strip_cur = (state == WAITING) ? fifo_rd_data.strip : strip_reg;

    always_ff @(posedge clk) begin
        strip_reg <= strip_cur;
    end

    // Bytes of the head beat that land in the output.
    assign use_bytes = bcnt_w'(line_bytes) - bcnt_w'(strip_cur);
    assign merge_last = fifo_rd_data_next.last &
                        (bcnt_w'(fifo_rd_data_next.padbytes) >= use_bytes);

    // Next entry may belong to another packet, or still be filling, after a last head.
    assign low_half = fifo_rd_data.last ? '0 : fifo_rd_data_next.data;
    assign realign_shift = shift_w'(strip_cur) << 3;
    assign realign_data = {fifo_rd_data.data, low_half} << realign_shift;
    assign realign_dst_data = realign_data[2*data_w-1 -: data_w];

    assign realign_dst_data_padbytes = realign_dst_data_last
                                     ? pad_src + padbytes_t'(strip_cur)
                                     : '0; // Wraps to the merged count.

    always_comb begin
        state_next = state;
        fifo_rd_req = 1'b0;
        realign_dst_data_val = 1'b0;
        realign_dst_data_last = 1'b0;
        pad_src = fifo_rd_data.padbytes;
        case (state)
            WAITING, READING_DATA: begin
                if ((fifo_num_els != '0) && fifo_rd_data.last) begin
                    realign_dst_data_val = 1'b1;
                    realign_dst_data_last = 1'b1;
                    fifo_rd_req = dst_realign_data_rdy;
                    if (dst_realign_data_rdy) begin
                        state_next = WAITING;
                    end
                end else if (fifo_num_els > 1) begin
                    realign_dst_data_val = 1'b1;
                    realign_dst_data_last = merge_last; // Last beat fits in this output.
                    fifo_rd_req = dst_realign_data_rdy;
                    if (merge_last) begin
                        pad_src = fifo_rd_data_next.padbytes;
                    end
                    if (dst_realign_data_rdy) begin
                        state_next = merge_last ? DRAIN_ELEMENT : READING_DATA;
                    end
                end
            end
            DRAIN_ELEMENT: begin
                fifo_rd_req = 1'b1; // Already sent, just pop it.
                state_next = WAITING;
            end
            default: begin
                state_next = WAITING;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WAITING;
        end else begin
            state <= state_next;
        end
    end

    peek_fifo #(
        .data_w ($bits(entry_t)),
        .els    (buf_stages)
    ) i_fifo (
        .clk          (clk),
        .rst          (rst),
        .wr_req       (fifo_wr_req),
        .wr_data      (fifo_wr_data),
        .full         (fifo_full),
        .rd_req       (fifo_rd_req),
        .rd_data      (fifo_rd_data),
        .rd_data_next (fifo_rd_data_next),
        .num_els      (fifo_num_els)
    );

endmodule

/* hdr_strip_top.sv */
`timescale 1ns/100ps
`include "strip_defs.svh"

module hdr_strip_top (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in_val,
    input  stream_pkg::data_t     in_data,
    input  stream_pkg::padbytes_t in_padbytes,
    input  logic                  in_last,
    output logic                  in_rdy,

    output logic                  out_val,
    output stream_pkg::data_t     out_data,
    output stream_pkg::padbytes_t out_padbytes,
    output logic                  out_last,
    input  logic                  out_rdy
);
    import stream_pkg::*;

    logic      cls_val;
    data_t     cls_data;
    padbytes_t cls_padbytes;
    logic      cls_last;
    strip_t    cls_strip;
    logic      cls_rdy;

    hdr_classify i_classify (
        .clk          (clk),
        .rst          (rst),
        .in_val       (in_val),
        .in_data      (in_data),
        .in_padbytes  (in_padbytes),
        .in_last      (in_last),
        .in_rdy       (in_rdy),
        .cls_val      (cls_val),
        .cls_data     (cls_data),
        .cls_padbytes (cls_padbytes),
        .cls_last     (cls_last),
        .cls_strip    (cls_strip),
        .cls_rdy      (cls_rdy)
    );

    realign_runtime #(
        .data_w     (`STRIP_DATA_W),
        .buf_stages (`STRIP_BUF_STAGES)
    ) i_realign (
        .clk                       (clk),
        .rst                       (rst),
        .realign_bytes             (cls_strip),
        .src_realign_data_val      (cls_val),
        .src_realign_data          (cls_data),
        .src_realign_data_padbytes (cls_padbytes),
        .src_realign_data_last     (cls_last),
        .realign_src_data_rdy      (cls_rdy),
        .realign_dst_data_val      (out_val),
        .realign_dst_data          (out_data),
        .realign_dst_data_padbytes (out_padbytes),
        .realign_dst_data_last     (out_last),
        .dst_realign_data_rdy      (out_rdy)
    );

endmodule

/* hdr_strip_asserts.sv */
`timescale 1ns/100ps

module hdr_strip_asserts (
    input logic                  clk,
    input logic                  rst,
    input logic                  in_val,
    input stream_pkg::padbytes_t in_padbytes,
    input logic                  in_last,
    input logic                  in_rdy,
    input logic                  out_val,
    input stream_pkg::data_t     out_data,
    input stream_pkg::padbytes_t out_padbytes,
    input logic                  out_last,
    input logic                  out_rdy
);
    import stream_pkg::*;

    localparam int unsigned beat_bytes = $bits(data_t) / 8;

    int unsigned in_bytes;
    int unsigned out_bytes;

    function automatic int unsigned beat_len(input logic last, input padbytes_t pad);
        if (last) begin
            return beat_bytes - 32'(pad);
        end
        return beat_bytes;
    endfunction

    // Running byte counts on both sides.
    always_ff @(posedge clk) begin
        if (rst) begin
            in_bytes <= 0;
            out_bytes <= 0;
        end else begin
            if (in_val && in_rdy) begin
                in_bytes <= in_bytes + beat_len(in_last, in_padbytes);
            end
            if (out_val && out_rdy) begin
                out_bytes <= out_bytes + beat_len(out_last, out_padbytes);
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) rst |=> !out_val)
        else $error("out_val high right after reset");

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_val && !out_rdy |=> out_val && $stable(out_data) && $stable(out_last)
                                && $stable(out_padbytes))
        else $error("Output beat changed while out_rdy was low");

    a_pad_zero: assert property (@(posedge clk) disable iff (rst)
        !out_last |-> out_padbytes == '0)
        else $error("out_padbytes nonzero on a beat that is not last");

    a_byte_count: assert property (@(posedge clk) disable iff (rst) out_bytes <= in_bytes)
        else $error("More bytes left the pipeline than entered it");

endmodule

bind hdr_strip_top hdr_strip_asserts i_asserts (
    .clk          (clk),
    .rst          (rst),
    .in_val       (in_val),
    .in_padbytes  (in_padbytes),
    .in_last      (in_last),
    .in_rdy       (in_rdy),
    .out_val      (out_val),
    .out_data     (out_data),
    .out_padbytes (out_padbytes),
    .out_last     (out_last),
    .out_rdy      (out_rdy)
);

/* tb_hdr_strip.sv */
`timescale 1ns/100ps
`include "strip_defs.svh"

module tb_hdr_strip;
    import stream_pkg::*;
    import hdr_pkg::*;

    localparam int clk_period_ns = 20;
    localparam int beat_bytes = `STRIP_DATA_W / 8;
    localparam int num_pkts = 200;
    localparam int max_len = 40;
    localparam int watchdog_ns = num_pkts * 40 * clk_period_ns;

    typedef logic [7:0] byte_q_t[$];

    logic      clk;
    logic      rst;
    logic      in_val;
    data_t     in_data;
    padbytes_t in_padbytes;
    logic      in_last;
    logic      in_rdy;
    logic      out_val;
    data_t     out_data;
    padbytes_t out_padbytes;
    logic      out_last;
    logic      out_rdy;

    int seed;
    int stall_cycles;
    int beats_checked;

    data_t     drv_data_q[$];
    padbytes_t drv_pad_q[$];
    logic      drv_last_q[$];
    data_t     exp_data_q[$];
    padbytes_t exp_pad_q[$];
    logic      exp_last_q[$];

    hdr_strip_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .in_val       (in_val),
        .in_data      (in_data),
        .in_padbytes  (in_padbytes),
        .in_last      (in_last),
        .in_rdy       (in_rdy),
        .out_val      (out_val),
        .out_data     (out_data),
        .out_padbytes (out_padbytes),
        .out_last     (out_last),
        .out_rdy      (out_rdy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period_ns / 2) clk = ~clk;
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_data(input data_t exp, input data_t act);
        if (act !== exp) begin
            report_failure($sformatf("FAIL %0t out_data expected %h actual %h", $time, exp, act));
        end
    endtask

    task automatic check_padbytes(input padbytes_t exp, input padbytes_t act);
        if (act !== exp) begin
            report_failure($sformatf("FAIL %0t out_padbytes expected %0d actual %0d",
                                     $time, exp, act));
        end
    endtask

    task automatic check_last(input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("FAIL %0t out_last expected %b actual %b", $time, exp, act));
        end
    endtask

    // Header bytes removed for each opcode.
    function automatic int strip_for_opcode(input logic [7:0] opcode);
        case (opcode)
            KIND_RAW:  return 0;
            KIND_TAG:  return 2;
            KIND_TUN:  return 4;
            KIND_LONG: return 6;
            default:   return 1;
        endcase
    endfunction

    function automatic padbytes_t pad_for_len(input int n);
        return padbytes_t'((beat_bytes - n % beat_bytes) % beat_bytes);
    endfunction

    // MSB first, unused low bytes are zero.
    function automatic data_t beat_of(input byte_q_t bytes, input int start);
        data_t beat;
        beat = '0;
        for (int i = 0; i < beat_bytes; i++) begin
            if (start + i < bytes.size()) begin
                beat[`STRIP_DATA_W-1-8*i -: 8] = bytes[start + i];
            end
        end
        return beat;
    endfunction

    task automatic push_beats(input byte_q_t bytes, input logic to_dut);
        logic      last;
        padbytes_t pad;
        for (int b = 0; b < bytes.size(); b += beat_bytes) begin
            last = (b + beat_bytes >= bytes.size());
            pad = last ? pad_for_len(bytes.size()) : '0;
            if (to_dut) begin
                drv_data_q.push_back(beat_of(bytes, b));
                drv_pad_q.push_back(pad);
                drv_last_q.push_back(last);
            end else begin
                exp_data_q.push_back(beat_of(bytes, b));
                exp_pad_q.push_back(pad);
                exp_last_q.push_back(last);
            end
        end
    endtask

    task automatic add_packet(input logic [7:0] opcode, input int len);
        byte_q_t pkt;
        byte_q_t payload;
        int      n_strip;
        n_strip = strip_for_opcode(opcode);
        pkt.push_back(opcode);
        for (int i = 1; i < len; i++) begin
            pkt.push_back(8'($random(seed)));
        end
        for (int i = n_strip; i < len; i++) begin
            payload.push_back(pkt[i]);
        end
        push_beats(pkt, 1'b1);
        push_beats(payload, 1'b0);
    endtask

    task automatic build_packets();
        logic [7:0] opcode;
        int         sel;
        int         len;
        add_packet(KIND_RAW, 16);  // Two whole beats, passed through.
        add_packet(KIND_TAG, 20);
        add_packet(KIND_TUN, 13);
        add_packet(KIND_LONG, 10); // Tail merges into the first output.
        add_packet(8'ha5, 9);      // Reserved kind.
        for (int p = 5; p < num_pkts; p++) begin
            sel = int'({$random(seed)} % 5);
            if (sel < 4) begin
                opcode = 8'(sel);
            end else begin
                opcode = 8'(4 + {$random(seed)} % 252);
            end
            len = strip_for_opcode(opcode) + 1;
            len = len + int'({$random(seed)} % (max_len + 1 - len));
            add_packet(opcode, len);
        end
    endtask

    task automatic send_beats();
        int idx;
        idx = 0;
        while (idx < drv_data_q.size()) begin
            @(negedge clk);
            in_val = 1'b1;
            in_data = drv_data_q[idx];
            in_padbytes = drv_pad_q[idx];
            in_last = drv_last_q[idx];
            @(posedge clk);
            if (in_rdy) begin
                idx++;
            end
        end
        @(negedge clk);
        in_val = 1'b0;
    endtask

    initial begin
        seed = 32'hdd467653;
        rst = 1'b1;
        in_val = 1'b0;
        in_data = '0;
        in_padbytes = '0;
        in_last = 1'b0;
        out_rdy = 1'b0;
        stall_cycles = 0;
        beats_checked = 0;
        build_packets();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        send_beats();
        while (exp_data_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk); // Room for a stray extra beat to show up.
        if (stall_cycles != 0) begin
            $display("Checked %0d output beats from %0d packets", beats_checked, num_pkts);
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_failure("in_rdy never dropped, back-pressure did not reach the input");
        end
    end

    // Output back-pressure, low about a third of the time.
    initial begin
        forever begin
            @(negedge clk);
            out_rdy = ({$random(seed)} % 3) != 0;
        end
    end

    always @(posedge clk) begin
        if (!rst && in_val && !in_rdy) begin
            stall_cycles++;
        end
        if (!rst && out_val && out_rdy) begin
            if (exp_data_q.size() == 0) begin
                report_failure("An output beat arrived when no more beats were expected");
            end else begin
                check_data(exp_data_q.pop_front(), out_data);
                check_padbytes(exp_pad_q.pop_front(), out_padbytes);
                check_last(exp_last_q.pop_front(), out_last);
                beats_checked++;
            end
        end
    end

    initial begin
        #(watchdog_ns);
        report_failure($sformatf("Watchdog expired, output stalled with %0d beats still expected",
                                 exp_data_q.size()));
    end

endmodule

/* all.f */
+incdir+.
stream_pkg.sv
hdr_pkg.sv
peek_fifo.sv
hdr_classify.sv
realign_runtime.sv
hdr_strip_top.sv
hdr_strip_asserts.sv
tb_hdr_strip.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the header-strip testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_hdr_strip -f all.f \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vtb_hdr_strip 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -q "^Simulation finished: PASS$" && exit 0 || exit 1
